/* design/eth_core.sv */
`timescale 1ns/1ps

module eth_core #(
   parameter logic [47:0] ETH_MAC_ADDR = eth_pkg::DEFAULT_MAC,
   parameter int PHY_RST_CYCLES = 1000000
) (
   input  logic                          clk,
   input  logic                          rst_int,
   input  logic                          valid,
   input  logic                          wstrb,
   input  logic [eth_pkg::ETH_ADDR_W-1:0] addr,
   input  logic [31:0]                   data_in,
   output logic                          ready,
   output logic [31:0]                   data_out,
   output logic                          phy_resetn,
   input  logic [3:0]                    rx_data,
   input  logic                          rx_dv,
   output logic                          tx_en,
   output logic [3:0]                    tx_data
);

   logic                            core_rst;
   logic                            tx_wr;
   logic                            send;
   logic                            rcv_ack;
   logic [eth_pkg::NBYTES_W-1:0]    tx_nbytes;
   logic [eth_pkg::NBYTES_W-1:0]    rx_nbytes;
   logic [31:0]                     dummy;

   logic [eth_pkg::BUF_ADDR_W-1:0]  tx_rd_addr;
   logic [7:0]                      tx_rd_data;
   logic                            tx_ready;

   logic                            rx_wr;
   logic [eth_pkg::BUF_ADDR_W-1:0]  rx_wr_addr;
   logic [7:0]                      rx_wr_data;
   logic [7:0]                      rx_rd_data;
   logic                            rx_rcvd;
   logic [eth_pkg::NBYTES_W-1:0]    rx_count;
   logic                            crc_ok;
   logic [31:0]                     crc_value;

   eth_reg_decode #(
      .PHY_RST_CYCLES(PHY_RST_CYCLES)
   ) i_reg_decode (
      .clk        (clk),
      .rst_int    (rst_int),
      .valid      (valid),
      .wstrb      (wstrb),
      .addr       (addr),
      .data_in    (data_in),
      .core_rst   (core_rst),
      .tx_wr      (tx_wr),
      .send       (send),
      .rcv_ack    (rcv_ack),
      .tx_nbytes  (tx_nbytes),
      .rx_nbytes  (rx_nbytes),
      .dummy      (dummy),
      .phy_resetn (phy_resetn)
   );

   // Host fills the transmit buffer through the data window
   eth_frame_buffer #(
      .DEPTH_W(eth_pkg::BUF_ADDR_W)
   ) i_tx_buffer (
      .clk   (clk),
      .we    (tx_wr),
      .waddr (addr[eth_pkg::BUF_ADDR_W-1:0]),
      .wdata (data_in[7:0]),
      .raddr (tx_rd_addr),
      .rdata (tx_rd_data)
   );

   eth_frame_buffer #(
      .DEPTH_W(eth_pkg::BUF_ADDR_W)
   ) i_rx_buffer (
      .clk   (clk),
      .we    (rx_wr),
      .waddr (rx_wr_addr),
      .wdata (rx_wr_data),
      .raddr (addr[eth_pkg::BUF_ADDR_W-1:0]),
      .rdata (rx_rd_data)
   );

   eth_tx_engine i_tx_engine (
      .clk      (clk),
      .core_rst (core_rst),
      .send     (send),
      .nbytes   (tx_nbytes),
      .rd_addr  (tx_rd_addr),
      .rd_data  (tx_rd_data),
      .tx_ready (tx_ready),
      .tx_en    (tx_en),
      .tx_data  (tx_data)
   );

   eth_rx_engine #(
      .ETH_MAC_ADDR(ETH_MAC_ADDR)
   ) i_rx_engine (
      .clk       (clk),
      .core_rst  (core_rst),
      .rx_data   (rx_data),
      .rx_dv     (rx_dv),
      .nbytes    (rx_nbytes),
      .rcv_ack   (rcv_ack),
      .wr        (rx_wr),
      .wr_addr   (rx_wr_addr),
      .wr_data   (rx_wr_data),
      .rx_rcvd   (rx_rcvd),
      .rx_count  (rx_count),
      .crc_ok    (crc_ok),
      .crc_value (crc_value)
   );

   eth_read_back i_read_back (
      .clk        (clk),
      .rst_int    (rst_int),
      .core_rst   (core_rst),
      .valid      (valid),
      .addr       (addr),
      .rx_rd_data (rx_rd_data),
      .tx_ready   (tx_ready),
      .rx_rcvd    (rx_rcvd),
      .phy_resetn (phy_resetn),
      .crc_ok     (crc_ok),
      .rx_count   (rx_count),
      .crc_value  (crc_value),
      .dummy      (dummy),
      .ready      (ready),
      .data_out   (data_out)
   );

endmodule

/* design/eth_crc32.sv */
`timescale 1ns/1ps

module eth_crc32 (
   input  logic        clk,
   input  logic        core_rst,
   input  logic        init,
   input  logic        en,
   input  logic [3:0]  nibble,
   output logic [31:0] crc
);

   // Four reflected steps, LSB of the nibble first
   function automatic logic [31:0] next_crc(input logic [31:0] c, input logic [3:0] d);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 4; i++) begin
         if (r[0] ^ d[i]) begin
            r = (r >> 1) ^ eth_pkg::CRC_POLY;
         end else begin
            r = r >> 1;
         end
      end
      return r;
   endfunction

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         crc <= '1;
      end else if (init) begin
         crc <= '1;
      end else if (en) begin
         crc <= next_crc(crc, nibble);
      end
   end

endmodule

/* design/eth_frame_buffer.sv */
`timescale 1ns/1ps

module eth_frame_buffer #(
   parameter int DEPTH_W = 11
) (
   input  logic               clk,
   input  logic               we,
   input  logic [DEPTH_W-1:0] waddr,
   input  logic [7:0]         wdata,
   input  logic [DEPTH_W-1:0] raddr,
   output logic [7:0]         rdata
);

   logic [7:0] mem [0:(1 << DEPTH_W) - 1];

   // Read returns old contents on a same-address write
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

endmodule

/* design/eth_pkg.sv */
package eth_pkg;

   // Host address and buffer geometry
   localparam int ETH_ADDR_W = 12;
   localparam int BUF_ADDR_W = 11;
   localparam int NBYTES_W = 11;

   // Register map, word addresses below the data window
   localparam logic [ETH_ADDR_W-1:0] ADDR_STATUS = 12'd0;
   localparam logic [ETH_ADDR_W-1:0] ADDR_SEND = 12'd1;
   localparam logic [ETH_ADDR_W-1:0] ADDR_RCVACK = 12'd2;
   localparam logic [ETH_ADDR_W-1:0] ADDR_DUMMY = 12'd3;
   localparam logic [ETH_ADDR_W-1:0] ADDR_TX_NBYTES = 12'd4;
   localparam logic [ETH_ADDR_W-1:0] ADDR_RX_NBYTES = 12'd5;
   localparam logic [ETH_ADDR_W-1:0] ADDR_SOFTRST = 12'd6;
   localparam logic [ETH_ADDR_W-1:0] ADDR_CRC = 12'd7;

   localparam logic [NBYTES_W-1:0] NBYTES_RESET = 11'd46;

   // Status word bit positions
   localparam int ST_TX_READY = 0;
   localparam int ST_RX_RCVD = 1;
   localparam int ST_PHY_RESETN = 2;
   localparam int ST_CRC_OK = 3;
   localparam int ST_RX_COUNT_LSB = 4;

   // Preamble nibbles, then one delimiter nibble
   localparam int PREAMBLE_NIBBLES = 15;
   localparam logic [3:0] PREAMBLE_NIB = 4'h5;
   localparam logic [3:0] SFD_NIB = 4'hD;

   localparam logic [31:0] CRC_POLY = 32'hEDB88320;
   localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

   localparam logic [47:0] DEFAULT_MAC = 48'h02_00_5E_10_00_01;

endpackage

/* design/eth_read_back.sv */
`timescale 1ns/1ps

module eth_read_back (
   input  logic                          clk,
   input  logic                          rst_int,
   input  logic                          core_rst,
   input  logic                          valid,
   input  logic [eth_pkg::ETH_ADDR_W-1:0] addr,
   input  logic [7:0]                    rx_rd_data,
   input  logic                          tx_ready,
   input  logic                          rx_rcvd,
   input  logic                          phy_resetn,
   input  logic                          crc_ok,
   input  logic [eth_pkg::NBYTES_W-1:0]  rx_count,
   input  logic [31:0]                   crc_value,
   input  logic [31:0]                   dummy,
   output logic                          ready,
   output logic [31:0]                   data_out
);

   logic [31:0] status;
   logic [31:0] word_q;
   logic        window_q;

   always_comb begin
      status = '0;
      status[eth_pkg::ST_TX_READY] = tx_ready;
      status[eth_pkg::ST_RX_RCVD] = rx_rcvd;
      status[eth_pkg::ST_PHY_RESETN] = phy_resetn;
      status[eth_pkg::ST_CRC_OK] = crc_ok;
      status[eth_pkg::ST_RX_COUNT_LSB +: eth_pkg::NBYTES_W] = rx_count;
   end

   // One-cycle host handshake
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ready <= 1'b0;
      end else begin
         ready <= valid;
      end
   end

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         word_q <= '0;
         window_q <= 1'b0;
      end else if (valid) begin
         window_q <= addr[eth_pkg::ETH_ADDR_W-1];
         case (addr)
            eth_pkg::ADDR_STATUS: word_q <= status;
            eth_pkg::ADDR_DUMMY:  word_q <= dummy;
            eth_pkg::ADDR_CRC:    word_q <= crc_value;
            default:              word_q <= '0;
         endcase
      end
   end

   // RAM read is registered, so the byte lands in the ready cycle too
   assign data_out = window_q ? {24'h000000, rx_rd_data} : word_q;

endmodule

/* design/eth_reg_decode.sv */
`timescale 1ns/1ps

module eth_reg_decode #(
   parameter int PHY_RST_CYCLES = 1000000
) (
   input  logic                          clk,
   input  logic                          rst_int,
   input  logic                          valid,
   input  logic                          wstrb,
   input  logic [eth_pkg::ETH_ADDR_W-1:0] addr,
   input  logic [31:0]                   data_in,
   output logic                          core_rst,
   output logic                          tx_wr,
   output logic                          send,
   output logic                          rcv_ack,
   output logic [eth_pkg::NBYTES_W-1:0]  tx_nbytes,
   output logic [eth_pkg::NBYTES_W-1:0]  rx_nbytes,
   output logic [31:0]                   dummy,
   output logic                          phy_resetn
);

   localparam int CNT_W = $clog2(PHY_RST_CYCLES);

   logic             wr;
   logic             soft_rst;
   logic [CNT_W-1:0] phy_cnt;

   assign wr = valid & wstrb;

   // Top address bit selects the byte window
   assign tx_wr = wr & addr[eth_pkg::ETH_ADDR_W-1];
   assign send = wr & (addr == eth_pkg::ADDR_SEND);
   assign rcv_ack = wr & (addr == eth_pkg::ADDR_RCVACK);

   assign core_rst = rst_int | soft_rst;

   // Soft reset lasts exactly one cycle
   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         soft_rst <= 1'b0;
      end else begin
         soft_rst <= wr & (addr == eth_pkg::ADDR_SOFTRST) & ~soft_rst;
      end
   end

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         tx_nbytes <= eth_pkg::NBYTES_RESET;
         rx_nbytes <= eth_pkg::NBYTES_RESET;
         dummy <= '0;
      end else if (wr) begin
         case (addr)
            eth_pkg::ADDR_DUMMY:     dummy <= data_in;
            eth_pkg::ADDR_TX_NBYTES: tx_nbytes <= data_in[eth_pkg::NBYTES_W-1:0];
            eth_pkg::ADDR_RX_NBYTES: rx_nbytes <= data_in[eth_pkg::NBYTES_W-1:0];
            default: ;
         endcase
      end
   end

   // PHY held in reset for PHY_RST_CYCLES after any reset
   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         phy_cnt <= '0;
         phy_resetn <= 1'b0;
      end else if (phy_cnt != CNT_W'(PHY_RST_CYCLES - 1)) begin
         phy_cnt <= phy_cnt + 1'b1;
      end else begin
         phy_resetn <= 1'b1;
      end
   end

endmodule

/* design/eth_rx_engine.sv */
`timescale 1ns/1ps

module eth_rx_engine #(
   parameter logic [47:0] ETH_MAC_ADDR = eth_pkg::DEFAULT_MAC
) (
   input  logic                           clk,
   input  logic                           core_rst,
   input  logic [3:0]                     rx_data,
   input  logic                           rx_dv,
   input  logic [eth_pkg::NBYTES_W-1:0]   nbytes,
   input  logic                           rcv_ack,
   output logic                           wr,
   output logic [eth_pkg::BUF_ADDR_W-1:0] wr_addr,
   output logic [7:0]                     wr_data,
   output logic                           rx_rcvd,
   output logic [eth_pkg::NBYTES_W-1:0]   rx_count,
   output logic                           crc_ok,
   output logic [31:0]                    crc_value
);

   function automatic logic [31:0] bit_rev(input logic [31:0] v);
      logic [31:0] r;
      for (int i = 0; i < 32; i++) begin
         r[i] = v[31 - i];
      end
      return r;
   endfunction

   // Residue is defined MSB first, the CRC register is reflected
   localparam logic [31:0] RESIDUE = bit_rev(eth_pkg::CRC_RESIDUE);
   localparam logic [eth_pkg::NBYTES_W-1:0] MIN_FRAME = 18;

   typedef enum logic [1:0] {
      st_hunt,
      st_data,
      st_skip
   } rx_state_t;

   rx_state_t                    state;
   logic                         phase;
   logic [3:0]                   lo_nib;
   logic [eth_pkg::NBYTES_W-1:0] count;
   logic [47:0]                  mac_sr;
   logic                         addr_ok;
   logic                         bcast_ok;
   logic [31:0]                  crc;
   logic                         sfd_seen;
   logic                         byte_done;
   logic                         frame_end;
   logic                         good_crc;
   logic                         accept;

   assign sfd_seen = (state == st_hunt) & rx_dv & ~rx_rcvd & (rx_data == eth_pkg::SFD_NIB);
   assign byte_done = (state == st_data) & rx_dv & phase;
   assign frame_end = (state == st_data) & ~rx_dv;
   assign good_crc = (crc == RESIDUE);
   assign accept = (addr_ok | bcast_ok) & good_crc & (count >= MIN_FRAME);

   // Bytes past nbytes still count toward the length
   assign wr = byte_done & (count < nbytes);
   assign wr_addr = count[eth_pkg::BUF_ADDR_W-1:0];
   assign wr_data = {rx_data, lo_nib};

   eth_crc32 i_crc (
      .clk      (clk),
      .core_rst (core_rst),
      .init     (sfd_seen),
      .en       ((state == st_data) & rx_dv),
      .nibble   (rx_data),
      .crc      (crc)
   );

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         state <= st_hunt;
         phase <= 1'b0;
         lo_nib <= '0;
         count <= '0;
         mac_sr <= '0;
         addr_ok <= 1'b0;
         bcast_ok <= 1'b0;
         rx_rcvd <= 1'b0;
         rx_count <= '0;
         crc_ok <= 1'b0;
         crc_value <= '0;
      end else begin
         if (rcv_ack) begin
            rx_rcvd <= 1'b0;
         end
         case (state)
            st_hunt: begin
               // A frame starting while the last one is unread is dropped whole
               if (rx_dv & rx_rcvd) begin
                  state <= st_skip;
               end else if (sfd_seen) begin
                  state <= st_data;
                  phase <= 1'b0;
                  count <= '0;
                  mac_sr <= ETH_MAC_ADDR;
                  addr_ok <= 1'b1;
                  bcast_ok <= 1'b1;
               end
            end
            st_data: begin
               if (frame_end) begin
                  state <= st_hunt;
                  rx_count <= count;
                  crc_value <= crc;
                  crc_ok <= good_crc;
                  if (accept) begin
                     rx_rcvd <= 1'b1;
                  end
               end else begin
                  phase <= ~phase;
                  if (!phase) begin
                     lo_nib <= rx_data;
                  end else begin
                     count <= count + 1'b1;
                     // Destination address, most significant byte first
                     if (count < 6) begin
                        addr_ok <= addr_ok & (wr_data == mac_sr[47:40]);
                        bcast_ok <= bcast_ok & (wr_data == 8'hFF);
                        mac_sr <= mac_sr << 8;
                     end
                  end
               end
            end
            st_skip: begin
               if (!rx_dv) begin
                  state <= st_hunt;
               end
            end
            default: state <= st_hunt;
         endcase
      end
   end

endmodule

/* design/eth_tx_engine.sv */
`timescale 1ns/1ps

module eth_tx_engine (
   input  logic                           clk,
   input  logic                           core_rst,
   input  logic                           send,
   input  logic [eth_pkg::NBYTES_W-1:0]   nbytes,
   output logic [eth_pkg::BUF_ADDR_W-1:0] rd_addr,
   input  logic [7:0]                     rd_data,
   output logic                           tx_ready,
   output logic                           tx_en,
   output logic [3:0]                     tx_data
);

   typedef enum logic [1:0] {
      st_idle,
      st_preamble,
      st_payload,
      st_fcs
   } tx_state_t;

   tx_state_t                    state;
   logic [3:0]                   cnt;
   logic [eth_pkg::NBYTES_W-1:0] n_q;
   logic [3:0]                   hi_nib;
   logic [31:0]                  crc;

   assign tx_ready = (state == st_idle);
   assign tx_en = ~tx_ready;

   // Payload: low nibble straight from the RAM, high nibble from hi_nib
   always_comb begin
      case (state)
         st_preamble: begin
            tx_data = (cnt == 4'(eth_pkg::PREAMBLE_NIBBLES)) ?
                      eth_pkg::SFD_NIB : eth_pkg::PREAMBLE_NIB;
         end
         st_payload: tx_data = cnt[0] ? hi_nib : rd_data[3:0];
         st_fcs:     tx_data = ~crc[{cnt[2:0], 2'b00} +: 4];
         default:    tx_data = 4'h0;
      endcase
   end

   eth_crc32 i_crc (
      .clk      (clk),
      .core_rst (core_rst),
      .init     (tx_ready),
      .en       (state == st_payload),
      .nibble   (tx_data),
      .crc      (crc)
   );

   always_ff @(posedge clk or posedge core_rst) begin
      if (core_rst) begin
         state <= st_idle;
         cnt <= '0;
         n_q <= '0;
         rd_addr <= '0;
         hi_nib <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (send) begin
                  state <= st_preamble;
                  cnt <= '0;
                  n_q <= nbytes;
                  rd_addr <= '0;
               end
            end
            st_preamble: begin
               cnt <= cnt + 1'b1;
               if (cnt == 4'(eth_pkg::PREAMBLE_NIBBLES)) begin
                  cnt <= '0;
                  state <= (n_q == '0) ? st_fcs : st_payload;
               end
            end
            st_payload: begin
               cnt <= {3'b000, ~cnt[0]};
               if (!cnt[0]) begin
                  // Next byte is fetched while the high nibble goes out
                  hi_nib <= rd_data[7:4];
                  rd_addr <= rd_addr + 1'b1;
               end else if (rd_addr == n_q) begin
                  state <= st_fcs;
               end
            end
            st_fcs: begin
               cnt <= cnt + 1'b1;
               if (cnt == 4'd7) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

/* project.f */
design/eth_pkg.sv
design/eth_frame_buffer.sv
design/eth_crc32.sv
design/eth_reg_decode.sv
design/eth_tx_engine.sv
design/eth_rx_engine.sv
design/eth_read_back.sv
design/eth_core.sv
sim/eth_clk_gen.sv
sim/tb_eth_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module tb_eth_core \
   && ./obj_dir/Vtb_eth_core > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log \
   && { echo "Simulation reported failures"; exit 1; } \
   || { echo "Simulation clean"; exit 0; }

/* sim/eth_clk_gen.sv */
`timescale 1ns/1ps

module eth_clk_gen #(
   parameter int HALF_PERIOD_NS = 4
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // 8 ns period
   always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

/* sim/tb_eth_core.sv */
`timescale 1ns/1ps

module tb_eth_core;

   localparam logic [47:0] STATION_MAC = 48'h02_5A_3C_11_22_77;
   localparam int PHY_RST_CYCLES = 32;
   // Longest frame is under 250 cycles, the whole run stays well below 1500
   localparam int MAX_CYCLES = 4000;

   logic                          clk;
   logic                          rst_int;
   logic                          valid;
   logic                          wstrb;
   logic [eth_pkg::ETH_ADDR_W-1:0] addr;
   logic [31:0]                   data_in;
   logic                          ready;
   logic [31:0]                   data_out;
   logic                          phy_resetn;
   logic [3:0]                    rx_data;
   logic                          rx_dv;
   logic                          tx_en;
   logic [3:0]                    tx_data;

   // Bytes of the frame under test, and nibbles seen on the transmit side
   logic [7:0] frame[$];
   logic [3:0] tx_nibs[$];

   string test_name;
   int    err_cnt = 0;
   int    test_cnt = 0;
   int    fail_cnt = 0;
   int    errs_at_start = 0;
   int    cycle_cnt = 0;

   eth_clk_gen i_clk_gen (
      .clk(clk)
   );

   eth_core #(
      .ETH_MAC_ADDR   (STATION_MAC),
      .PHY_RST_CYCLES (PHY_RST_CYCLES)
   ) i_eth_core (
      .clk        (clk),
      .rst_int    (rst_int),
      .valid      (valid),
      .wstrb      (wstrb),
      .addr       (addr),
      .data_in    (data_in),
      .ready      (ready),
      .data_out   (data_out),
      .phy_resetn (phy_resetn),
      .rx_data    (rx_data),
      .rx_dv      (rx_dv),
      .tx_en      (tx_en),
      .tx_data    (tx_data)
   );

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      assert (cond) else begin
         $display("Test %s: %s", test_name, msg);
         err_cnt++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      errs_at_start = err_cnt;
      test_cnt++;
   endtask

   task automatic end_test();
      if (err_cnt == errs_at_start) begin
         $display("Test %s: ok", test_name);
      end else begin
         fail_cnt++;
         $display("Test %s: %0d check(s) wrong", test_name, err_cnt - errs_at_start);
      end
   endtask

   task automatic host_write(input logic [11:0] a, input logic [31:0] d);
      @(posedge clk);
      #1;
      valid = 1'b1;
      wstrb = 1'b1;
      addr = a;
      data_in = d;
      @(posedge clk);
      #1;
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   // Ready must be low in the access cycle and high in the next one
   task automatic host_read(input logic [11:0] a, output logic [31:0] d);
      @(posedge clk);
      #1;
      valid = 1'b1;
      wstrb = 1'b0;
      addr = a;
      check_eq("ready before accept", 32'h0, {31'h0, ready});
      @(posedge clk);
      #1;
      valid = 1'b0;
      check_eq("ready after accept", 32'h1, {31'h0, ready});
      d = data_out;
   endtask

   // Reflected CRC-32 register over the first len bytes, no final inversion
   function automatic logic [31:0] crc_reg(input int len);
      logic [31:0] c;
      c = 32'hFFFF_FFFF;
      for (int i = 0; i < len; i++) begin
         c = c ^ {24'h0, frame[i]};
         for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
         end
      end
      return c;
   endfunction

   task automatic fill_tx_buffer(input int n);
      frame.delete();
      for (int i = 0; i < n; i++) begin
         frame.push_back(8'($urandom()));
         host_write(12'h800 + 12'(i), {24'h0, frame[i]});
      end
   endtask

   task automatic collect_tx();
      int w;
      tx_nibs.delete();
      w = 0;
      @(negedge clk);
      while (!tx_en && w < 4) begin
         @(negedge clk);
         w++;
      end
      check_true(tx_en, "tx_en did not rise after the send write");
      while (tx_en) begin
         tx_nibs.push_back(tx_data);
         @(negedge clk);
      end
   endtask

   task automatic check_tx_frame(input int n);
      logic [31:0] fcs;
      logic [7:0]  b;
      logic [3:0]  exp;
      fcs = ~crc_reg(n);
      check_eq("nibble count", 32'(16 + 2 * n + 8), 32'(tx_nibs.size()));
      if (tx_nibs.size() == 16 + 2 * n + 8) begin
         for (int i = 0; i < 16 + 2 * n + 8; i++) begin
            if (i < 15) begin
               exp = 4'h5;
            end else if (i == 15) begin
               exp = 4'hD;
            end else if (i < 16 + 2 * n) begin
               b = frame[(i - 16) / 2];
               exp = ((i - 16) % 2 == 0) ? b[3:0] : b[7:4];
            end else begin
               exp = fcs[4 * (i - 16 - 2 * n) +: 4];
            end
            check_eq($sformatf("nibble %0d", i), {28'h0, exp}, {28'h0, tx_nibs[i]});
         end
      end
   endtask

   // Destination MSB first, random rest, FCS appended low byte first
   task automatic make_rx_frame(input logic [47:0] dst, input int len);
      logic [31:0] fcs;
      frame.delete();
      for (int k = 0; k < 6; k++) begin
         frame.push_back(dst[47 - 8 * k -: 8]);
      end
      for (int k = 6; k < len; k++) begin
         frame.push_back(8'($urandom()));
      end
      fcs = ~crc_reg(frame.size());
      for (int k = 0; k < 4; k++) begin
         frame.push_back(fcs[8 * k +: 8]);
      end
   endtask

   task automatic drive_rx_frame();
      @(posedge clk);
      #1;
      rx_dv = 1'b1;
      for (int i = 0; i < 15; i++) begin
         rx_data = 4'h5;
         @(posedge clk);
         #1;
      end
      rx_data = 4'hD;
      @(posedge clk);
      #1;
      for (int i = 0; i < frame.size(); i++) begin
         rx_data = frame[i][3:0];
         @(posedge clk);
         #1;
         rx_data = frame[i][7:4];
         @(posedge clk);
         #1;
      end
      rx_dv = 1'b0;
      rx_data = 4'h0;
   endtask

   task automatic wait_rcvd(output logic seen);
      logic [31:0] st;
      seen = 1'b0;
      for (int i = 0; i < 4 && !seen; i++) begin
         host_read(eth_pkg::ADDR_STATUS, st);
         seen = st[eth_pkg::ST_RX_RCVD];
      end
   endtask

   task automatic check_rx_bytes(input int first);
      logic [31:0] rd;
      for (int i = first; i < frame.size(); i++) begin
         host_read(12'h800 + 12'(i), rd);
         check_eq($sformatf("rx byte %0d", i), {24'h0, frame[i]}, rd);
      end
   endtask

   initial begin
      logic [31:0] rd;
      logic [31:0] r;
      logic        seen;
      int          idx;
      void'($urandom(32'h29b3_0217));
      rst_int = 1'b1;
      valid = 1'b0;
      wstrb = 1'b0;
      addr = '0;
      data_in = '0;
      rx_data = 4'h0;
      rx_dv = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_int = 1'b0;

      begin_test("reset_regs");
      check_eq("phy_resetn pin at reset", 32'h0, {31'h0, phy_resetn});
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("status low bits", 32'h1, {29'h0, rd[2:0]});
      // Status read took two of the cycles
      repeat (PHY_RST_CYCLES - 3) @(posedge clk);
      #1;
      check_eq("phy_resetn pin early", 32'h0, {31'h0, phy_resetn});
      @(posedge clk);
      #1;
      check_eq("phy_resetn pin", 32'h1, {31'h0, phy_resetn});
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("phy_resetn", 32'h1, {31'h0, rd[eth_pkg::ST_PHY_RESETN]});
      host_write(eth_pkg::ADDR_DUMMY, 32'h5A5A_1234);
      host_read(eth_pkg::ADDR_DUMMY, rd);
      check_eq("scratch", 32'h5A5A_1234, rd);
      r = $urandom();
      host_write(eth_pkg::ADDR_DUMMY, r);
      host_read(eth_pkg::ADDR_DUMMY, rd);
      check_eq("scratch random", r, rd);
      end_test();

      begin_test("transmit");
      fill_tx_buffer(20);
      host_write(eth_pkg::ADDR_TX_NBYTES, 32'd20);
      host_write(eth_pkg::ADDR_SEND, 32'h1);
      collect_tx();
      check_tx_frame(20);
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("tx_ready after frame", 32'h1, {31'h0, rd[eth_pkg::ST_TX_READY]});
      end_test();

      begin_test("receive_accept");
      make_rx_frame(STATION_MAC, 24);
      drive_rx_frame();
      wait_rcvd(seen);
      check_true(seen, "rx_rcvd did not rise after a good frame");
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("crc_ok", 32'h1, {31'h0, rd[eth_pkg::ST_CRC_OK]});
      check_eq("rx_count", 32'd28, {21'h0, rd[14:4]});
      host_read(eth_pkg::ADDR_CRC, rd);
      check_eq("crc register", crc_reg(frame.size()), rd);
      check_rx_bytes(0);
      host_write(eth_pkg::ADDR_RCVACK, 32'h1);
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("rx_rcvd after ack", 32'h0, {31'h0, rd[eth_pkg::ST_RX_RCVD]});
      end_test();

      begin_test("receive_reject");
      make_rx_frame(STATION_MAC ^ 48'h0000_0000_0100, 24);
      drive_rx_frame();
      repeat (4) @(posedge clk);
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("rx_rcvd wrong address", 32'h0, {31'h0, rd[eth_pkg::ST_RX_RCVD]});
      make_rx_frame(STATION_MAC, 24);
      idx = frame.size() - 1;
      frame[idx] = frame[idx] ^ 8'h80;
      drive_rx_frame();
      repeat (4) @(posedge clk);
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("rx_rcvd bad crc", 32'h0, {31'h0, rd[eth_pkg::ST_RX_RCVD]});
      check_eq("crc_ok bad crc", 32'h0, {31'h0, rd[eth_pkg::ST_CRC_OK]});
      make_rx_frame(STATION_MAC, 24);
      drive_rx_frame();
      wait_rcvd(seen);
      check_true(seen, "rx_rcvd did not rise before the broadcast frame");
      // Broadcast of a different length while the last frame is unread
      make_rx_frame(48'hFFFF_FFFF_FFFF, 20);
      drive_rx_frame();
      repeat (4) @(posedge clk);
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("rx_count kept", 32'd28, {21'h0, rd[14:4]});
      host_write(eth_pkg::ADDR_RCVACK, 32'h1);
      host_read(eth_pkg::ADDR_STATUS, rd);
      check_eq("rx_rcvd after broadcast", 32'h0, {31'h0, rd[eth_pkg::ST_RX_RCVD]});
      end_test();

      begin_test("soft_reset");
      fill_tx_buffer(46);
      host_write(eth_pkg::ADDR_TX_NBYTES, 32'd20);
      host_write(eth_pkg::ADDR_RX_NBYTES, 32'd10);
      host_write(eth_pkg::ADDR_DUMMY, 32'hC3C3_0F0F);
      host_write(eth_pkg::ADDR_SOFTRST, 32'h1);
      host_read(eth_pkg::ADDR_DUMMY, rd);
      check_eq("scratch after soft reset", 32'h0, rd);
      host_write(eth_pkg::ADDR_SEND, 32'h1);
      collect_tx();
      check_tx_frame(46);
      // Bytes past offset 10 are only stored if rx_nbytes is back to 46
      make_rx_frame(STATION_MAC, 24);
      drive_rx_frame();
      wait_rcvd(seen);
      check_true(seen, "rx_rcvd did not rise after soft reset");
      check_rx_bytes(10);
      end_test();

      $display("Summary: %0d tests, %0d failed, %0d check errors", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
